// File: flist.f
+incdir+source
source/csr_pkg.sv
source/csr_access.sv
source/csr_trap.sv
source/csr_timer.sv
source/csr_unit.sv
sim/csr_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the CSR unit testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
{ verilator --binary --assert --timing --timescale 1ns/100ps \
    --top-module csr_tb -f flist.f -o csr_sim \
    && ./obj_dir/csr_sim; } > "$LOG" 2>&1 \
    || echo "CHECKS FAILED" >> "$LOG"
cat "$LOG"
grep -q "CHECKS FAILED" "$LOG" && echo "RESULT: FAIL" && exit 1 || echo "RESULT: PASS"
exit 0

// File: sim/csr_tb.sv
// CSR unit testbench
// Runs register access, access exceptions, trap entry and return, the
// external and timer interrupts and the counters through the CSR unit
`include "csr_macros.svh"

module csr_tb;

timeunit 1ns;
timeprecision 100ps;

import csr_pkg::*;

logic                       clk;
logic                       rst_n;
logic                       r_req;
logic [`CSR_ADDR_W-1:0]     rw_addr;
logic [`CSR_XLEN-1:0]       r_data;
logic                       w_req;
csr_cmd_e                   w_cmd;
logic [`CSR_XLEN-1:0]       w_data;
logic                       rw_exc;
logic                       take_exc;
logic                       take_irq;
logic                       take_eret;
csr_exc_code_e              exc_code;
logic [`CSR_XLEN-1:0]       exc_badaddr;
logic [`CSR_XLEN-1:0]       new_pc;
logic                       irq;
logic                       irq_pen;
logic [`CSR_XLEN-1:0]       curr_pc;
logic [`CSR_XLEN-1:0]       next_pc;
logic                       instret;
logic                       ext_irq;
logic [`CSR_XLEN-1:0]       fuse_mhartid;

int unsigned                cyc_cnt = 0;    // Free-running edge count
int unsigned                read_cyc;       // Edge count at the last read
logic                       addr_in_map;

csr_unit dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .r_req        (r_req),
    .rw_addr      (rw_addr),
    .r_data       (r_data),
    .w_req        (w_req),
    .w_cmd        (w_cmd),
    .w_data       (w_data),
    .rw_exc       (rw_exc),
    .take_exc     (take_exc),
    .take_irq     (take_irq),
    .take_eret    (take_eret),
    .exc_code     (exc_code),
    .exc_badaddr  (exc_badaddr),
    .new_pc       (new_pc),
    .irq          (irq),
    .irq_pen      (irq_pen),
    .curr_pc      (curr_pc),
    .next_pc      (next_pc),
    .instret      (instret),
    .ext_irq      (ext_irq),
    .fuse_mhartid (fuse_mhartid)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

// Machine CSR map
assign addr_in_map = rw_addr inside {
    `CSR_ADDR_MCPUID, `CSR_ADDR_MIMPID, `CSR_ADDR_MHARTID, `CSR_ADDR_MSTATUS,
    `CSR_ADDR_MTVEC, `CSR_ADDR_MIE, `CSR_ADDR_MTIMECMP, `CSR_ADDR_MTIME,
    `CSR_ADDR_MTIMEH, `CSR_ADDR_MTIMECLKSET, `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC,
    `CSR_ADDR_MCAUSE, `CSR_ADDR_MBADADDR, `CSR_ADDR_MIP, `CSR_ADDR_CYCLE,
    `CSR_ADDR_CYCLEH, `CSR_ADDR_INSTRET, `CSR_ADDR_INSTRETH};

// --------------------------------------------------
// Reporting
// --------------------------------------------------
task automatic report_mismatch(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    $display("Mismatch %s: expected 0x%h, actual 0x%h", name, exp, act);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
endtask

task automatic fail_run(input string what);
    $display("Error: %s", what);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
endtask

task automatic check_value(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    assert (act === exp) else report_mismatch(name, exp, act);
endtask

// Mapped addresses never raise an access exception
assert property (@(posedge clk) disable iff (!rst_n)
    ((r_req || w_req) && addr_in_map) |-> !rw_exc)
    else fail_run("rw_exc raised for a mapped CSR address");

// Traps always vector to mtvec
assert property (@(posedge clk) disable iff (!rst_n)
    (take_exc || take_irq) |-> (new_pc == `CSR_MTVEC_VAL))
    else report_mismatch("trap new_pc", `CSR_MTVEC_VAL, $sampled(new_pc));

// --------------------------------------------------
// Stimulus tasks
// --------------------------------------------------
task automatic csr_read(input logic [11:0] addr, output logic [31:0] data,
                        output logic exc);
    @(posedge clk);
    #1;
    r_req   = 1'b1;
    rw_addr = addr;
    @(negedge clk);
    data     = r_data;                  // Combinational in the request cycle
    exc      = rw_exc;
    read_cyc = cyc_cnt;
    @(posedge clk);
    #1;
    r_req = 1'b0;
endtask

task automatic csr_write(input logic [11:0] addr, input csr_cmd_e cmd,
                         input logic [31:0] data, output logic exc);
    @(posedge clk);
    #1;
    w_req   = 1'b1;
    rw_addr = addr;
    w_cmd   = cmd;
    w_data  = data;
    @(negedge clk);
    exc = rw_exc;
    @(posedge clk);
    #1;
    w_req = 1'b0;
    w_cmd = CMD_NONE;
endtask

task automatic read_expect(input string name, input logic [11:0] addr,
                           input logic [31:0] exp);
    logic [31:0] rd;
    logic        exc;
    csr_read(addr, rd, exc);
    check_value(name, exp, rd);
endtask

task automatic raise_exception(input csr_exc_code_e code, input logic [31:0] badaddr,
                               input logic [31:0] pc);
    @(posedge clk);
    #1;
    take_exc    = 1'b1;
    exc_code    = code;
    exc_badaddr = badaddr;
    curr_pc     = pc;
    @(posedge clk);
    #1;
    take_exc = 1'b0;
endtask

task automatic accept_interrupt(input logic [31:0] pc);
    @(posedge clk);
    #1;
    take_irq = 1'b1;
    next_pc  = pc;
    @(posedge clk);
    #1;
    take_irq = 1'b0;
endtask

task automatic return_from_trap(input logic [31:0] exp_pc);
    @(posedge clk);
    #1;
    take_eret = 1'b1;
    @(negedge clk);
    check_value("eret new_pc", exp_pc, new_pc);
    @(posedge clk);
    #1;
    take_eret = 1'b0;
endtask

task automatic pulse_instret(input int n);
    @(posedge clk);
    #1;
    instret = 1'b1;
    repeat (n) @(posedge clk);
    #1;
    instret = 1'b0;
endtask

task automatic wait_timer_pending(input int limit);
    logic [31:0] mip;
    logic        exc;
    int          n;
    n   = 0;
    mip = '0;
    while (!mip[`CSR_MIE_MTIE_BIT]) begin
        if (n == limit) begin
            fail_run("timeout waiting for mip.mtip to rise");
        end else begin
            csr_read(`CSR_ADDR_MIP, mip, exc);
            n++;
        end
    end
endtask

// --------------------------------------------------
// Test sequence
// --------------------------------------------------
initial begin
    logic [31:0] rd;
    logic [31:0] rd_b;
    logic        exc;
    logic [31:0] exp;
    logic [31:0] d;
    logic [31:0] pc;
    logic [31:0] diff;
    int unsigned c1;
    int unsigned div;

    void'($urandom(21));
    rst_n        = 1'b0;
    r_req        = 1'b0;
    rw_addr      = '0;
    w_req        = 1'b0;
    w_cmd        = CMD_NONE;
    w_data       = '0;
    take_exc     = 1'b0;
    take_irq     = 1'b0;
    take_eret    = 1'b0;
    exc_code     = EXC_INSTR_MISALIGN;
    exc_badaddr  = '0;
    curr_pc      = '0;
    next_pc      = '0;
    instret      = 1'b0;
    ext_irq      = 1'b0;
    fuse_mhartid = 32'h0000_0003;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Register access, write then set then clear
    d = $urandom;
    csr_write(`CSR_ADDR_MSCRATCH, CMD_WRITE, d, exc);
    exp = d;
    read_expect("mscratch write", `CSR_ADDR_MSCRATCH, exp);
    d = $urandom;
    csr_write(`CSR_ADDR_MSCRATCH, CMD_SET, d, exc);
    exp = exp | d;
    read_expect("mscratch set", `CSR_ADDR_MSCRATCH, exp);
    d = $urandom;
    csr_write(`CSR_ADDR_MSCRATCH, CMD_CLEAR, d, exc);
    exp = exp & ~d;
    read_expect("mscratch clear", `CSR_ADDR_MSCRATCH, exp);
    read_expect("mcpuid", `CSR_ADDR_MCPUID, `CSR_MCPUID_VAL);
    read_expect("mhartid", `CSR_ADDR_MHARTID, fuse_mhartid);
    csr_write(`CSR_ADDR_MTVEC, CMD_WRITE, $urandom, exc);
    check_value("mtvec write exc", 32'h0, 32'(exc));
    read_expect("mtvec", `CSR_ADDR_MTVEC, `CSR_MTVEC_VAL);

    // Access exceptions on unused addresses
    csr_read(12'h7FF, rd, exc);
    check_value("unmapped read exc", 32'h1, 32'(exc));
    csr_write(12'h123, CMD_WRITE, $urandom, exc);
    check_value("unmapped write exc", 32'h1, 32'(exc));

    // Exception trap with IE0 set beforehand
    csr_write(`CSR_ADDR_MSTATUS, CMD_WRITE, 32'h1 << `CSR_MSTATUS_IE0_BIT, exc);
    d  = $urandom;
    pc = $urandom;
    raise_exception(EXC_LOAD_ACCESS, d, pc);
    read_expect("exc mepc", `CSR_ADDR_MEPC, pc & ~32'h3);
    read_expect("exc mcause", `CSR_ADDR_MCAUSE, 32'(EXC_LOAD_ACCESS));
    read_expect("exc mbadaddr", `CSR_ADDR_MBADADDR, d);
    csr_read(`CSR_ADDR_MSTATUS, rd, exc);
    check_value("exc ie0", 32'h0, 32'(rd[`CSR_MSTATUS_IE0_BIT]));
    check_value("exc ie1", 32'h1, 32'(rd[`CSR_MSTATUS_IE1_BIT]));
    return_from_trap(pc & ~32'h3);
    csr_read(`CSR_ADDR_MSTATUS, rd, exc);
    check_value("eret ie0", 32'h1, 32'(rd[`CSR_MSTATUS_IE0_BIT]));

    // External interrupt
    csr_write(`CSR_ADDR_MIE, CMD_WRITE, 32'h1 << `CSR_MIE_MEIE_BIT, exc);
    ext_irq = 1'b1;                     // Still at edge plus 1 ns
    @(negedge clk);
    check_value("ext irq", 32'h1, 32'(irq));
    check_value("ext irq_pen", 32'h1, 32'(irq_pen));
    pc = $urandom;
    accept_interrupt(pc);
    ext_irq = 1'b0;
    read_expect("irq mcause", `CSR_ADDR_MCAUSE, 32'h8000_000B);
    read_expect("irq mepc", `CSR_ADDR_MEPC, pc & ~32'h3);
    csr_read(`CSR_ADDR_MSTATUS, rd, exc);
    check_value("irq ie0", 32'h0, 32'(rd[`CSR_MSTATUS_IE0_BIT]));
    csr_write(`CSR_ADDR_MIE, CMD_WRITE, 32'h0, exc);

    // Timer prescaler
    div = 3;
    csr_write(`CSR_ADDR_MTIMECLKSET, CMD_WRITE, div, exc);
    csr_read(`CSR_ADDR_MTIME, rd, exc);
    c1 = read_cyc;
    repeat (40) @(posedge clk);
    csr_read(`CSR_ADDR_MTIME, rd_b, exc);
    exp  = (read_cyc - c1) / div;
    diff = rd_b - rd;
    assert (diff + 1 >= exp && diff <= exp + 1)
        else report_mismatch("time prescaler", exp, diff);

    // Timer compare and interrupt
    csr_write(`CSR_ADDR_MTIME, CMD_WRITE, 32'h0000_0100, exc);
    csr_write(`CSR_ADDR_MTIMECMP, CMD_WRITE, 32'h0000_0108, exc);
    wait_timer_pending(100);
    @(negedge clk);
    check_value("timer irq_pen", 32'h1, 32'(irq_pen));
    csr_write(`CSR_ADDR_MIE, CMD_WRITE, 32'h1 << `CSR_MIE_MTIE_BIT, exc);
    csr_write(`CSR_ADDR_MSTATUS, CMD_WRITE, 32'h1 << `CSR_MSTATUS_IE0_BIT, exc);
    @(negedge clk);
    check_value("timer irq", 32'h1, 32'(irq));
    csr_write(`CSR_ADDR_MTIMECMP, CMD_WRITE, 32'hFFFF_0000, exc);
    csr_read(`CSR_ADDR_MIP, rd, exc);
    check_value("mtip after cmp write", 32'h0, 32'(rd[`CSR_MIE_MTIE_BIT]));
    @(negedge clk);
    check_value("irq_pen after cmp write", 32'h0, 32'(irq_pen));
    csr_write(`CSR_ADDR_MIE, CMD_WRITE, 32'h0, exc);

    // Cycle counter
    csr_read(`CSR_ADDR_CYCLE, rd, exc);
    c1 = read_cyc;
    repeat (23) @(posedge clk);
    csr_read(`CSR_ADDR_CYCLE, rd_b, exc);
    check_value("cycle delta", read_cyc - c1, rd_b - rd);

    // Instret counts from reset and ignores writes
    pulse_instret(37);
    csr_write(`CSR_ADDR_INSTRET, CMD_WRITE, 32'hFFFF_FFFF, exc);
    check_value("instret write exc", 32'h0, 32'(exc));
    csr_write(`CSR_ADDR_INSTRETH, CMD_WRITE, 32'hFFFF_FFFF, exc);
    read_expect("instret", `CSR_ADDR_INSTRET, 32'd37);
    read_expect("instreth", `CSR_ADDR_INSTRETH, 32'h0);

    $display("ALL CHECKS PASSED");
    $finish;
end

endmodule

// File: source/csr_access.sv
// CSR access stage
// Decodes the address, muxes read data and forms write data by command.
// Issues write strobes to the trap and timer stages and holds mscratch.
`include "csr_macros.svh"

module csr_access (
    input  logic                        clk,
    input  logic                        rst_n,
    // Core request
    input  logic                        r_req,
    input  logic                        w_req,
    input  logic [`CSR_ADDR_W-1:0]      rw_addr,
    input  csr_pkg::csr_cmd_e           w_cmd,
    input  logic [`CSR_XLEN-1:0]        w_data,
    output logic [`CSR_XLEN-1:0]        r_data,
    output logic                        rw_exc,
    input  logic [`CSR_XLEN-1:0]        fuse_mhartid,
    input  logic                        ext_irq,
    // Trap stage state
    input  logic                        mstatus_ie0,
    input  logic                        mstatus_ie1,
    input  logic                        mie_mtie,
    input  logic                        mie_meie,
    input  logic [`CSR_XLEN-1:0]        mepc,
    input  logic                        mcause_irq,
    input  csr_pkg::csr_exc_code_e      mcause_ec,
    input  logic [`CSR_XLEN-1:0]        mbadaddr,
    // Timer stage state
    input  logic [`CSR_CNT_W-1:0]       time_val,
    input  logic [`CSR_CNT_W-1:0]       cycle_val,
    input  logic [`CSR_CNT_W-1:0]       instret_val,
    input  logic [`CSR_XLEN-1:0]        mtimecmp_val,
    input  logic [`CSR_CLKSET_W-1:0]    clkset_val,
    input  logic                        mtip,
    // Write side
    output logic [`CSR_XLEN-1:0]        wdata,
    output logic                        mstatus_up,
    output logic                        mie_up,
    output logic                        mepc_up,
    output logic                        mtimecmp_up,
    output logic                        time_up,
    output logic                        timeh_up,
    output logic                        clkset_up
);

import csr_pkg::*;

logic [`CSR_XLEN-1:0]   mscratch;
logic                   mscratch_up;
logic                   addr_known;     // Address is in the map
logic                   wr_en;

//--------------------------------------------------
// Read mux
//--------------------------------------------------
always_comb begin
    r_data     = '0;
    addr_known = 1'b1;
    case (rw_addr)
        `CSR_ADDR_MCPUID      : r_data = `CSR_MCPUID_VAL;
        `CSR_ADDR_MIMPID      : r_data = `CSR_MIMPID_VAL;
        `CSR_ADDR_MHARTID     : r_data = fuse_mhartid;
        `CSR_ADDR_MSTATUS     : begin
            r_data[`CSR_MSTATUS_IE0_BIT +: 3] = {`CSR_MSTATUS_PRV_VAL, mstatus_ie0};
            r_data[`CSR_MSTATUS_IE1_BIT +: 3] = {`CSR_MSTATUS_PRV_VAL, mstatus_ie1};
        end
        `CSR_ADDR_MTVEC       : r_data = `CSR_MTVEC_VAL;
        `CSR_ADDR_MIE         : begin
            r_data[`CSR_MIE_MTIE_BIT] = mie_mtie;
            r_data[`CSR_MIE_MEIE_BIT] = mie_meie;
        end
        `CSR_ADDR_MIP         : begin
            r_data[`CSR_MIE_MTIE_BIT] = mtip;
            r_data[`CSR_MIE_MEIE_BIT] = ext_irq;   // Not latched
        end
        `CSR_ADDR_MTIMECMP    : r_data = mtimecmp_val;
        `CSR_ADDR_MTIME       : r_data = time_val[`CSR_XLEN-1:0];
        `CSR_ADDR_MTIMEH      : r_data = time_val[`CSR_CNT_W-1:`CSR_XLEN];
        `CSR_ADDR_MTIMECLKSET : r_data[`CSR_CLKSET_W-1:0] = clkset_val;
        `CSR_ADDR_MSCRATCH    : r_data = mscratch;
        `CSR_ADDR_MEPC        : r_data = mepc;
        `CSR_ADDR_MCAUSE      : begin
            r_data[`CSR_XLEN-1]   = mcause_irq;
            r_data[`CSR_EC_W-1:0] = mcause_ec;
        end
        `CSR_ADDR_MBADADDR    : r_data = mbadaddr;
        `CSR_ADDR_CYCLE       : r_data = cycle_val[`CSR_XLEN-1:0];
        `CSR_ADDR_CYCLEH      : r_data = cycle_val[`CSR_CNT_W-1:`CSR_XLEN];
        `CSR_ADDR_INSTRET     : r_data = instret_val[`CSR_XLEN-1:0];
        `CSR_ADDR_INSTRETH    : r_data = instret_val[`CSR_CNT_W-1:`CSR_XLEN];
        default               : addr_known = 1'b0;
    endcase
end

assign rw_exc = (r_req | w_req) & ~addr_known;

//--------------------------------------------------
// Write data and strobes
//--------------------------------------------------
always_comb begin
    case (w_cmd)
        CMD_WRITE : wdata = w_data;
        CMD_SET   : wdata = r_data | w_data;     // Old value from read mux
        CMD_CLEAR : wdata = r_data & ~w_data;
        default   : wdata = '0;
    endcase
end

assign wr_en = w_req & (w_cmd != CMD_NONE);

always_comb begin
    mstatus_up  = 1'b0;
    mie_up      = 1'b0;
    mepc_up     = 1'b0;
    mscratch_up = 1'b0;
    mtimecmp_up = 1'b0;
    time_up     = 1'b0;
    timeh_up    = 1'b0;
    clkset_up   = 1'b0;
    if (wr_en) begin
        case (rw_addr)
            `CSR_ADDR_MSTATUS     : mstatus_up  = 1'b1;
            `CSR_ADDR_MIE         : mie_up      = 1'b1;
            `CSR_ADDR_MEPC        : mepc_up     = 1'b1;
            `CSR_ADDR_MSCRATCH    : mscratch_up = 1'b1;
            `CSR_ADDR_MTIMECMP    : mtimecmp_up = 1'b1;
            `CSR_ADDR_MTIME       : time_up     = 1'b1;
            `CSR_ADDR_MTIMEH      : timeh_up    = 1'b1;
            `CSR_ADDR_MTIMECLKSET : clkset_up   = 1'b1;
            default               : ;               // Read-only or unmapped
        endcase
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        mscratch <= '0;
    end else if (mscratch_up) begin
        mscratch <= wdata;
    end
end

endmodule

// File: source/csr_macros.svh
// CSR unit constants
// Widths, the machine CSR address map, reset values and bit positions
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// Widths
`define CSR_XLEN                32
`define CSR_ADDR_W              12
`define CSR_CNT_W               64
`define CSR_CLKSET_W            10
`define CSR_EC_W                4

// Address map
`define CSR_ADDR_MCPUID         12'hF00
`define CSR_ADDR_MIMPID         12'hF01
`define CSR_ADDR_MHARTID        12'hF10
`define CSR_ADDR_MSTATUS        12'h300
`define CSR_ADDR_MTVEC          12'h301
`define CSR_ADDR_MIE            12'h304
`define CSR_ADDR_MTIMECMP       12'h321
`define CSR_ADDR_MTIME          12'h701
`define CSR_ADDR_MTIMEH         12'h741
`define CSR_ADDR_MTIMECLKSET    12'h780     // Custom machine RW
`define CSR_ADDR_MSCRATCH       12'h340
`define CSR_ADDR_MEPC           12'h341
`define CSR_ADDR_MCAUSE         12'h342
`define CSR_ADDR_MBADADDR       12'h343
`define CSR_ADDR_MIP            12'h344
`define CSR_ADDR_CYCLE          12'hC00
`define CSR_ADDR_CYCLEH         12'hC80
`define CSR_ADDR_INSTRET        12'hC02
`define CSR_ADDR_INSTRETH       12'hC82

// Constant registers
`define CSR_MCPUID_VAL          32'h0000_0100   // RV32I
`define CSR_MIMPID_VAL          32'h0000_0001
`define CSR_MTVEC_VAL           32'h0000_01C0   // Also the trap target
`define CSR_CLKSET_RST          10'd4

// Bit positions
`define CSR_MSTATUS_IE0_BIT     0
`define CSR_MSTATUS_IE1_BIT     3
`define CSR_MSTATUS_PRV_VAL     2'b11           // Machine level only
`define CSR_MIE_MTIE_BIT        7
`define CSR_MIE_MEIE_BIT        11

`endif

// File: source/csr_pkg.sv
// CSR unit types
// Write command and trap cause encodings
`include "csr_macros.svh"

package csr_pkg;

    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_SET   = 2'd2,
        CMD_CLEAR = 2'd3
    } csr_cmd_e;

    typedef enum logic [`CSR_EC_W-1:0] {
        EXC_INSTR_MISALIGN = 4'd0,
        EXC_INSTR_ACCESS   = 4'd1,
        EXC_ILLEGAL_INSTR  = 4'd2,
        EXC_BREAKPOINT     = 4'd3,
        EXC_LOAD_MISALIGN  = 4'd4,
        EXC_LOAD_ACCESS    = 4'd5,
        EXC_STORE_MISALIGN = 4'd6,
        EXC_STORE_ACCESS   = 4'd7,
        EXC_ECALL          = 4'd8,
        IRQ_MEXT           = 4'd11   // Machine external interrupt
    } csr_exc_code_e;

    // Machine timer interrupt is code 7, told apart by the mcause interrupt bit
    localparam csr_exc_code_e IRQ_MTIMER = EXC_STORE_ACCESS;

endpackage

// File: source/csr_timer.sv
// CSR timer stage
// Prescaled 64-bit time counter with mtimecmp compare and the timer
// pending flag, plus the free-running cycle and instret counters.
`include "csr_macros.svh"

module csr_timer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        instret,
    // CSR writes
    input  logic [`CSR_XLEN-1:0]        wdata,
    input  logic                        mtimecmp_up,
    input  logic                        time_up,
    input  logic                        timeh_up,
    input  logic                        clkset_up,
    // Register state
    output logic [`CSR_CNT_W-1:0]       time_val,
    output logic [`CSR_CNT_W-1:0]       cycle_val,
    output logic [`CSR_CNT_W-1:0]       instret_val,
    output logic [`CSR_XLEN-1:0]        mtimecmp_val,
    output logic [`CSR_CLKSET_W-1:0]    clkset_val,
    output logic                        mtip
);

logic [`CSR_CLKSET_W-1:0]   presc_cnt;      // Cycles left to next tick
logic                       time_tick;
logic                       cmp_written;    // Compare armed

//--------------------------------------------------
// Prescaler
//--------------------------------------------------
always_ff @(posedge clk) begin
    if (!rst_n) begin
        clkset_val <= `CSR_CLKSET_RST;
    end else if (clkset_up) begin
        clkset_val <= wdata[`CSR_CLKSET_W-1:0];
    end
end

// Count 0 or 1 gives a tick; divider 0 and 1 both tick every cycle
assign time_tick = ~|presc_cnt[`CSR_CLKSET_W-1:1];

always_ff @(posedge clk) begin
    if (!rst_n) begin
        presc_cnt <= `CSR_CLKSET_RST;
    end else if (clkset_up) begin
        presc_cnt <= wdata[`CSR_CLKSET_W-1:0];     // Restart with new divider
    end else if (time_tick) begin
        presc_cnt <= clkset_val;
    end else begin
        presc_cnt <= presc_cnt - `CSR_CLKSET_W'(1);
    end
end

//--------------------------------------------------
// Time and compare
//--------------------------------------------------
always_ff @(posedge clk) begin
    if (!rst_n) begin
        time_val <= '0;
    end else if (time_up) begin
        time_val[`CSR_XLEN-1:0] <= wdata;
    end else if (timeh_up) begin
        time_val[`CSR_CNT_W-1:`CSR_XLEN] <= wdata;
    end else if (time_tick) begin
        time_val <= time_val + `CSR_CNT_W'(1);
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        mtimecmp_val <= '0;
        cmp_written  <= 1'b0;
    end else if (mtimecmp_up) begin
        mtimecmp_val <= wdata;
        cmp_written  <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        mtip <= 1'b0;
    end else if (mtimecmp_up) begin
        mtip <= 1'b0;                               // Write acknowledges
    end else if (cmp_written && (time_val[`CSR_XLEN-1:0] == mtimecmp_val)) begin
        mtip <= 1'b1;
    end
end

//--------------------------------------------------
// Performance counters
//--------------------------------------------------
always_ff @(posedge clk) begin
    if (!rst_n) begin
        cycle_val   <= '0;
        instret_val <= '0;
    end else begin
        cycle_val <= cycle_val + `CSR_CNT_W'(1);
        if (instret) begin
            instret_val <= instret_val + `CSR_CNT_W'(1);
        end
    end
end

endmodule

// File: source/csr_trap.sv
// CSR trap stage
// Holds mstatus, mie, mepc, mcause and mbadaddr, resolves trap and return
// events and drives the new PC and interrupt request outputs.
`include "csr_macros.svh"

module csr_trap (
    input  logic                        clk,
    input  logic                        rst_n,
    // Events
    input  logic                        take_exc,
    input  logic                        take_irq,
    input  logic                        take_eret,
    input  csr_pkg::csr_exc_code_e      exc_code,
    input  logic [`CSR_XLEN-1:0]        exc_badaddr,
    input  logic [`CSR_XLEN-1:0]        curr_pc,
    input  logic [`CSR_XLEN-1:0]        next_pc,
    // Interrupt sources
    input  logic                        ext_irq,
    input  logic                        mtip,
    // CSR writes
    input  logic [`CSR_XLEN-1:0]        wdata,
    input  logic                        mstatus_up,
    input  logic                        mie_up,
    input  logic                        mepc_up,
    // Register state
    output logic                        mstatus_ie0,
    output logic                        mstatus_ie1,
    output logic                        mie_mtie,
    output logic                        mie_meie,
    output logic [`CSR_XLEN-1:0]        mepc,
    output logic                        mcause_irq,
    output csr_pkg::csr_exc_code_e      mcause_ec,
    output logic [`CSR_XLEN-1:0]        mbadaddr,
    // To core
    output logic [`CSR_XLEN-1:0]        new_pc,
    output logic                        irq,
    output logic                        irq_pen
);

import csr_pkg::*;

logic [`CSR_XLEN-1:2]   mepc_q;         // Word aligned
logic                   ie0_new;        // Values after this cycle's write
logic                   mtie_new;
logic                   meie_new;
logic                   e_exc;
logic                   e_irq;
logic                   e_eret;
logic                   e_eret_irq;
logic                   badaddr_code;
csr_exc_code_e          irq_cause;

//--------------------------------------------------
// Event priority
//--------------------------------------------------
assign e_exc      = take_exc;
assign e_irq      = take_irq & ~take_exc & ~take_eret;
assign e_eret_irq = take_eret & take_irq & mstatus_ie1 & ~take_exc;
assign e_eret     = take_eret & ~take_exc & ~e_eret_irq;

assign badaddr_code = exc_code inside {EXC_INSTR_MISALIGN, EXC_INSTR_ACCESS,
                                       EXC_LOAD_MISALIGN,  EXC_LOAD_ACCESS,
                                       EXC_STORE_MISALIGN, EXC_STORE_ACCESS};

assign irq_cause = ext_irq ? IRQ_MEXT : IRQ_MTIMER;     // External wins

always_ff @(posedge clk) begin
    if (!rst_n) begin
        mstatus_ie0 <= 1'b0;
        mstatus_ie1 <= 1'b0;
        mepc_q      <= '0;
        mcause_irq  <= 1'b0;
        mcause_ec   <= EXC_INSTR_MISALIGN;
        mbadaddr    <= '0;
    end else if (e_exc) begin
        mstatus_ie0 <= 1'b0;                            // Push IE stack
        mstatus_ie1 <= mstatus_ie0;
        mepc_q      <= curr_pc[`CSR_XLEN-1:2];
        mcause_irq  <= 1'b0;
        mcause_ec   <= exc_code;
        if (badaddr_code) begin
            mbadaddr <= exc_badaddr;
        end
    end else if (e_irq) begin
        mstatus_ie0 <= 1'b0;
        mstatus_ie1 <= ie0_new;                         // Sees same-cycle write
        mepc_q      <= next_pc[`CSR_XLEN-1:2];
        mcause_irq  <= 1'b1;
        mcause_ec   <= irq_cause;
    end else if (e_eret) begin
        mstatus_ie0 <= mstatus_ie1;                     // Pop IE stack
        mstatus_ie1 <= 1'b1;
    end else if (e_eret_irq) begin
        // Return straight into the handler, mepc stays
        mstatus_ie0 <= 1'b0;
        mcause_irq  <= 1'b1;
        mcause_ec   <= irq_cause;
    end else if (mstatus_up) begin
        mstatus_ie0 <= wdata[`CSR_MSTATUS_IE0_BIT];
        mstatus_ie1 <= wdata[`CSR_MSTATUS_IE1_BIT];
    end else if (mepc_up) begin
        mepc_q      <= wdata[`CSR_XLEN-1:2];
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        mie_mtie <= 1'b0;
        mie_meie <= 1'b0;
    end else if (mie_up) begin
        mie_mtie <= wdata[`CSR_MIE_MTIE_BIT];
        mie_meie <= wdata[`CSR_MIE_MEIE_BIT];
    end
end

assign mepc = {mepc_q, 2'b00};

//--------------------------------------------------
// Interrupt request and new PC
//--------------------------------------------------
assign ie0_new  = mstatus_up ? wdata[`CSR_MSTATUS_IE0_BIT] : mstatus_ie0;
assign mtie_new = mie_up     ? wdata[`CSR_MIE_MTIE_BIT]    : mie_mtie;
assign meie_new = mie_up     ? wdata[`CSR_MIE_MEIE_BIT]    : mie_meie;

assign irq_pen = ext_irq | mtip;
assign irq     = ((ext_irq & meie_new) | (mtip & mtie_new)) & ie0_new;

assign new_pc  = e_eret ? mepc : `CSR_MTVEC_VAL;

endmodule

// File: source/csr_unit.sv
// Machine-mode CSR unit
// Connects the access, trap and timer stages
`include "csr_macros.svh"

module csr_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    // CSR read and write
    input  logic                        r_req,
    input  logic [`CSR_ADDR_W-1:0]      rw_addr,
    output logic [`CSR_XLEN-1:0]        r_data,
    input  logic                        w_req,
    input  csr_pkg::csr_cmd_e           w_cmd,
    input  logic [`CSR_XLEN-1:0]        w_data,
    output logic                        rw_exc,
    // Events
    input  logic                        take_exc,
    input  logic                        take_irq,
    input  logic                        take_eret,
    input  csr_pkg::csr_exc_code_e      exc_code,
    input  logic [`CSR_XLEN-1:0]        exc_badaddr,
    output logic [`CSR_XLEN-1:0]        new_pc,
    output logic                        irq,
    output logic                        irq_pen,
    // Core state
    input  logic [`CSR_XLEN-1:0]        curr_pc,
    input  logic [`CSR_XLEN-1:0]        next_pc,
    input  logic                        instret,
    input  logic                        ext_irq,
    input  logic [`CSR_XLEN-1:0]        fuse_mhartid
);

import csr_pkg::*;

logic [`CSR_XLEN-1:0]       wdata;
logic                       mstatus_up;
logic                       mie_up;
logic                       mepc_up;
logic                       mtimecmp_up;
logic                       time_up;
logic                       timeh_up;
logic                       clkset_up;
logic                       mstatus_ie0;
logic                       mstatus_ie1;
logic                       mie_mtie;
logic                       mie_meie;
logic [`CSR_XLEN-1:0]       mepc;
logic                       mcause_irq;
csr_exc_code_e              mcause_ec;
logic [`CSR_XLEN-1:0]       mbadaddr;
logic [`CSR_CNT_W-1:0]      time_val;
logic [`CSR_CNT_W-1:0]      cycle_val;
logic [`CSR_CNT_W-1:0]      instret_val;
logic [`CSR_XLEN-1:0]       mtimecmp_val;
logic [`CSR_CLKSET_W-1:0]   clkset_val;
logic                       mtip;

csr_access u_access (
    .clk          (clk),
    .rst_n        (rst_n),
    .r_req        (r_req),
    .w_req        (w_req),
    .rw_addr      (rw_addr),
    .w_cmd        (w_cmd),
    .w_data       (w_data),
    .r_data       (r_data),
    .rw_exc       (rw_exc),
    .fuse_mhartid (fuse_mhartid),
    .ext_irq      (ext_irq),
    .mstatus_ie0  (mstatus_ie0),
    .mstatus_ie1  (mstatus_ie1),
    .mie_mtie     (mie_mtie),
    .mie_meie     (mie_meie),
    .mepc         (mepc),
    .mcause_irq   (mcause_irq),
    .mcause_ec    (mcause_ec),
    .mbadaddr     (mbadaddr),
    .time_val     (time_val),
    .cycle_val    (cycle_val),
    .instret_val  (instret_val),
    .mtimecmp_val (mtimecmp_val),
    .clkset_val   (clkset_val),
    .mtip         (mtip),
    .wdata        (wdata),
    .mstatus_up   (mstatus_up),
    .mie_up       (mie_up),
    .mepc_up      (mepc_up),
    .mtimecmp_up  (mtimecmp_up),
    .time_up      (time_up),
    .timeh_up     (timeh_up),
    .clkset_up    (clkset_up)
);

csr_trap u_trap (
    .clk          (clk),
    .rst_n        (rst_n),
    .take_exc     (take_exc),
    .take_irq     (take_irq),
    .take_eret    (take_eret),
    .exc_code     (exc_code),
    .exc_badaddr  (exc_badaddr),
    .curr_pc      (curr_pc),
    .next_pc      (next_pc),
    .ext_irq      (ext_irq),
    .mtip         (mtip),
    .wdata        (wdata),
    .mstatus_up   (mstatus_up),
    .mie_up       (mie_up),
    .mepc_up      (mepc_up),
    .mstatus_ie0  (mstatus_ie0),
    .mstatus_ie1  (mstatus_ie1),
    .mie_mtie     (mie_mtie),
    .mie_meie     (mie_meie),
    .mepc         (mepc),
    .mcause_irq   (mcause_irq),
    .mcause_ec    (mcause_ec),
    .mbadaddr     (mbadaddr),
    .new_pc       (new_pc),
    .irq          (irq),
    .irq_pen      (irq_pen)
);

csr_timer u_timer (
    .clk          (clk),
    .rst_n        (rst_n),
    .instret      (instret),
    .wdata        (wdata),
    .mtimecmp_up  (mtimecmp_up),
    .time_up      (time_up),
    .timeh_up     (timeh_up),
    .clkset_up    (clkset_up),
    .time_val     (time_val),
    .cycle_val    (cycle_val),
    .instret_val  (instret_val),
    .mtimecmp_val (mtimecmp_val),
    .clkset_val   (clkset_val),
    .mtip         (mtip)
);

endmodule
